//--- ft_unit.f
common/ft_pkg.sv
logic/write_compare.sv
logic/shadow_regfile.sv
recovery/recovery_fsm.sv
recovery/debug_port_arbiter.sv
logic/ft_unit.sv
sim/ft_unit_checker.sv
sim/ft_unit_tb.sv

//--- Bender.yml
package:
  name: ft_unit

sources:
  # package first, then leaf blocks, then the top level
  - files:
      - common/ft_pkg.sv
      - logic/write_compare.sv
      - logic/shadow_regfile.sv
      - recovery/recovery_fsm.sv
      - recovery/debug_port_arbiter.sv
      - logic/ft_unit.sv

  # testbench and bound checker
  - target: simulation
    files:
      - sim/ft_unit_checker.sv
      - sim/ft_unit_tb.sv

//--- sim/ft_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ft_unit_tb;

	import ft_pkg::*;

	localparam int NUM_ROWS   = 16;
	// one recovery is about 45 cycles and a row costs one
	localparam int MAX_CYCLES = NUM_ROWS * 50;
	localparam int EXT_BEATS  = 8;
	localparam logic [31:0] SEED = 32'h1148_fc36;

	logic      clk_i;
	logic      arst_n_i;
	logic      we_a_i;
	reg_addr_t waddr_a_i;
	word_t     wdata_a_i;
	word_t     pc_a_i;
	logic      we_b_i;
	reg_addr_t waddr_b_i;
	word_t     wdata_b_i;
	word_t     pc_b_i;
	logic      halted_a_i;
	logic      halted_b_i;
	logic      ext_dbg_req_i;
	logic      ext_dbg_we_i;
	dbg_addr_t ext_dbg_addr_i;
	word_t     ext_dbg_wdata_i;
	logic      ext_dbg_halt_i;
	logic      ext_dbg_resume_i;
	logic      dbg_req_o;
	logic      dbg_we_o;
	dbg_addr_t dbg_addr_o;
	word_t     dbg_wdata_o;
	logic      dbg_halt_o;
	logic      dbg_resume_o;
	logic      error_o;
	logic      busy_o;

	// stimulus table of core a fields, core b fields and expected mismatch
	logic      t_we_a [NUM_ROWS];
	reg_addr_t t_addr_a [NUM_ROWS];
	word_t     t_data_a [NUM_ROWS];
	word_t     t_pc_a [NUM_ROWS];
	logic      t_we_b [NUM_ROWS];
	reg_addr_t t_addr_b [NUM_ROWS];
	word_t     t_data_b [NUM_ROWS];
	word_t     t_pc_b [NUM_ROWS];
	logic      t_mis [NUM_ROWS];
	int        n_rows = 0;

	// reference shadow that follows agreed rows only
	word_t     ref_regs [NUM_REGS];
	word_t     ref_pc;
	int        cycles = 0;
	int        pend;
	int        i;

	ft_unit i_dut (.*);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	////////////////////////////////////////
	// run limits
	////////////////////////////////////////

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: test still running after %0d cycles", cycles);
			$display("Test FAILED");
			$fatal(1, "timeout");
		end
	end

	always @(negedge clk_i) begin
		if (i_dut.i_checker.assert_hit) begin
			$display("a protocol assertion in the bound checker failed");
			$display("Test FAILED");
			$fatal(1, "assertion failure");
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task automatic expect_eq(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			$display("Test FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic add_row(input logic wa, input reg_addr_t aa, input word_t da,
		input word_t pa, input logic wb, input reg_addr_t ab, input word_t db,
		input word_t pb, input logic mis);
		t_we_a[n_rows]   = wa;
		t_addr_a[n_rows] = aa;
		t_data_a[n_rows] = da;
		t_pc_a[n_rows]   = pa;
		t_we_b[n_rows]   = wb;
		t_addr_b[n_rows] = ab;
		t_data_b[n_rows] = db;
		t_pc_b[n_rows]   = pb;
		t_mis[n_rows]    = mis;
		n_rows++;
	endtask

	task automatic build_table();
		// we_a addr_a data_a pc_a  we_b addr_b data_b pc_b  mismatch
		add_row(1'b1, 5'd1, 32'h1111_0001, 32'h100, 1'b1, 5'd1, 32'h1111_0001, 32'h100, 1'b0);
		add_row(1'b1, 5'd2, 32'h2222_0002, 32'h104, 1'b1, 5'd2, 32'h2222_0002, 32'h104, 1'b0);
		add_row(1'b1, 5'd31, 32'hdead_beef, 32'h108, 1'b1, 5'd31, 32'hdead_beef, 32'h108, 1'b0);
		// no write cycle so differing fields are ignored
		add_row(1'b0, 5'd4, 32'h0000_0000, 32'h000, 1'b0, 5'd9, 32'h0000_0001, 32'h004, 1'b0);
		// x0 write moves the pc but stores nothing
		add_row(1'b1, 5'd0, 32'h5555_5555, 32'h10c, 1'b1, 5'd0, 32'h5555_5555, 32'h10c, 1'b0);
		add_row(1'b1, 5'd5, 32'h0505_0505, 32'h110, 1'b1, 5'd5, 32'h0505_0505, 32'h110, 1'b0);
		// data differs
		add_row(1'b1, 5'd6, 32'h0000_0006, 32'h114, 1'b1, 5'd6, 32'h0000_0007, 32'h114, 1'b1);
		add_row(1'b1, 5'd7, 32'h7777_7777, 32'h118, 1'b1, 5'd7, 32'h7777_7777, 32'h118, 1'b0);
		add_row(1'b1, 5'd1, 32'haaaa_0001, 32'h11c, 1'b1, 5'd1, 32'haaaa_0001, 32'h11c, 1'b0);
		// address differs then lone enable while busy
		add_row(1'b1, 5'd8, 32'h0000_0808, 32'h120, 1'b1, 5'd9, 32'h0000_0808, 32'h120, 1'b1);
		add_row(1'b1, 5'd3, 32'h0000_0303, 32'h124, 1'b0, 5'd3, 32'h0000_0303, 32'h124, 1'b1);
		add_row(1'b1, 5'd3, 32'h3333_3333, 32'h128, 1'b1, 5'd3, 32'h3333_3333, 32'h128, 1'b0);
		// pc differs
		add_row(1'b1, 5'd4, 32'h0000_0404, 32'h12c, 1'b1, 5'd4, 32'h0000_0404, 32'h130, 1'b1);
		add_row(1'b1, 5'd10, 32'h1010_1010, 32'h134, 1'b1, 5'd10, 32'h1010_1010, 32'h134, 1'b0);
		add_row(1'b1, 5'd11, 32'h1111_1111, 32'h138, 1'b1, 5'd11, 32'h1111_1111, 32'h138, 1'b0);
		add_row(1'b1, 5'd12, 32'h1212_1212, 32'h13c, 1'b1, 5'd12, 32'h1212_1212, 32'h13c, 1'b0);
	endtask

	task automatic drive_row(input int r);
		we_a_i    <= t_we_a[r];
		waddr_a_i <= t_addr_a[r];
		wdata_a_i <= t_data_a[r];
		pc_a_i    <= t_pc_a[r];
		we_b_i    <= t_we_b[r];
		waddr_b_i <= t_addr_b[r];
		wdata_b_i <= t_data_b[r];
		pc_b_i    <= t_pc_b[r];
	endtask

	task automatic stop_writes();
		we_a_i <= 1'b0;
		we_b_i <= 1'b0;
	endtask

	// agreed write cycles move the reference checkpoint
	task automatic record_agreed(input int r);
		if (r < NUM_ROWS && !t_mis[r] && t_we_a[r]) begin
			if (t_addr_a[r] != '0) begin
				ref_regs[t_addr_a[r]] = t_data_a[r];
			end
			ref_pc = t_pc_a[r];
		end
	endtask

	// row result while the unit is idle
	task automatic check_row(input int r);
		expect_eq("error_o", error_o, t_mis[r]);
		expect_eq("dbg_halt_o", dbg_halt_o, 1'b0);
		expect_eq("busy_o", busy_o, 1'b0);
		record_agreed(r);
	endtask

	// row already launched when the error shows and halt must be up now
	task automatic settle_in_flight(input int r);
		@(posedge clk_i);
		stop_writes();
		@(negedge clk_i);
		expect_eq("error_o", error_o, (r < NUM_ROWS) ? t_mis[r] : 1'b0);
		expect_eq("dbg_halt_o", dbg_halt_o, 1'b1);
		expect_eq("busy_o", busy_o, 1'b1);
		record_agreed(r);
	endtask

	task automatic run_recovery();
		int        wait_cyc;
		dbg_addr_t exp_addr;
		word_t     exp_data;
		// cores take a while to enter debug mode
		wait_cyc = 2 + ($urandom % 8);
		for (int n = 0; n < wait_cyc; n++) begin
			@(posedge clk_i);
			if (n == wait_cyc - 1) begin
				halted_a_i <= 1'b1;
				halted_b_i <= 1'b1;
			end
			@(negedge clk_i);
			expect_eq("dbg_halt_o", dbg_halt_o, 1'b1);
			expect_eq("dbg_req_o", dbg_req_o, 1'b0);
			expect_eq("error_o", error_o, 1'b0);
		end
		// x1 .. x31 then npc back to back
		for (int w = 1; w <= NUM_REGS; w++) begin
			@(posedge clk_i);
			@(negedge clk_i);
			if (w < NUM_REGS) begin
				exp_addr = DBG_REG_BASE + dbg_addr_t'(4 * w);
				exp_data = ref_regs[w];
			end else begin
				exp_addr = DBG_NPC_ADDR;
				exp_data = ref_pc + INSTR_BYTES;
			end
			expect_eq("dbg_req_o", dbg_req_o, 1'b1);
			expect_eq("dbg_we_o", dbg_we_o, 1'b1);
			expect_eq("dbg_addr_o", dbg_addr_o, exp_addr);
			expect_eq("dbg_wdata_o", dbg_wdata_o, exp_data);
			expect_eq("dbg_resume_o", dbg_resume_o, 1'b0);
			expect_eq("busy_o", busy_o, 1'b1);
		end
		@(posedge clk_i);
		@(negedge clk_i);
		expect_eq("dbg_resume_o", dbg_resume_o, 1'b1);
		expect_eq("dbg_req_o", dbg_req_o, 1'b0);
		expect_eq("busy_o", busy_o, 1'b1);
		// cores leave debug mode after the pulse
		@(posedge clk_i);
		halted_a_i <= 1'b0;
		halted_b_i <= 1'b0;
		@(negedge clk_i);
		expect_eq("dbg_resume_o", dbg_resume_o, 1'b0);
		expect_eq("busy_o", busy_o, 1'b0);
		expect_eq("dbg_halt_o", dbg_halt_o, 1'b0);
	endtask

	// soc debug master alone with the outputs mirroring it
	task automatic ext_passthrough();
		logic [31:0] rnd;
		word_t       wdata;
		for (int n = 0; n < EXT_BEATS; n++) begin
			rnd   = $urandom;
			wdata = $urandom;
			@(posedge clk_i);
			ext_dbg_req_i    <= rnd[0];
			ext_dbg_we_i     <= rnd[1];
			ext_dbg_addr_i   <= rnd[16:2];
			ext_dbg_wdata_i  <= wdata;
			ext_dbg_halt_i   <= rnd[17];
			ext_dbg_resume_i <= rnd[18];
			@(negedge clk_i);
			expect_eq("dbg_req_o", dbg_req_o, rnd[0]);
			expect_eq("dbg_we_o", dbg_we_o, rnd[1]);
			expect_eq("dbg_addr_o", dbg_addr_o, rnd[16:2]);
			expect_eq("dbg_wdata_o", dbg_wdata_o, wdata);
			expect_eq("dbg_halt_o", dbg_halt_o, rnd[17]);
			expect_eq("dbg_resume_o", dbg_resume_o, rnd[18]);
			expect_eq("busy_o", busy_o, 1'b0);
		end
		@(posedge clk_i);
		ext_dbg_req_i    <= 1'b0;
		ext_dbg_we_i     <= 1'b0;
		ext_dbg_halt_i   <= 1'b0;
		ext_dbg_resume_i <= 1'b0;
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		void'($urandom(SEED));
		arst_n_i = 1'b0;
		we_a_i = 1'b0;
		waddr_a_i = '0;
		wdata_a_i = '0;
		pc_a_i = '0;
		we_b_i = 1'b0;
		waddr_b_i = '0;
		wdata_b_i = '0;
		pc_b_i = '0;
		halted_a_i = 1'b0;
		halted_b_i = 1'b0;
		ext_dbg_req_i = 1'b0;
		ext_dbg_we_i = 1'b0;
		ext_dbg_addr_i = '0;
		ext_dbg_wdata_i = '0;
		ext_dbg_halt_i = 1'b0;
		ext_dbg_resume_i = 1'b0;
		// shadow comes out of reset all zero
		for (int r = 0; r < NUM_REGS; r++) begin
			ref_regs[r] = '0;
		end
		ref_pc = '0;
		build_table();

		repeat (3) @(posedge clk_i);
		arst_n_i <= 1'b1;
		@(negedge clk_i);
		expect_eq("error_o", error_o, 1'b0);
		expect_eq("busy_o", busy_o, 1'b0);
		expect_eq("dbg_req_o", dbg_req_o, 1'b0);
		expect_eq("dbg_we_o", dbg_we_o, 1'b0);
		expect_eq("dbg_halt_o", dbg_halt_o, 1'b0);
		expect_eq("dbg_resume_o", dbg_resume_o, 1'b0);

		ext_passthrough();

		// one row per cycle with the previous row checked each cycle
		pend = -1;
		i = 0;
		while (i <= NUM_ROWS) begin
			@(posedge clk_i);
			if (i < NUM_ROWS) begin
				drive_row(i);
			end else begin
				stop_writes();
			end
			@(negedge clk_i);
			if (pend >= 0) begin
				check_row(pend);
			end
			if (pend >= 0 && t_mis[pend]) begin
				settle_in_flight(i);
				run_recovery();
				pend = -1;
			end else if (i < NUM_ROWS) begin
				pend = i;
			end else begin
				pend = -1;
			end
			i++;
		end

		repeat (2) @(posedge clk_i);
		if (i_dut.i_checker.assert_hit) begin
			$display("a protocol assertion in the bound checker failed");
			$display("Test FAILED");
			$fatal(1, "assertion failure");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- sim/ft_unit_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ft_unit_checker (
	input  wire   clk_i,
	input  wire   arst_n_i,
	// sequencer internals
	input  logic  rst_req_i,
	// top level pins
	input  logic  busy_i,
	input  logic  dbg_req_i,
	input  logic  dbg_we_i,
	input  logic  dbg_halt_i,
	input  logic  ext_dbg_halt_i,
	input  logic  dbg_resume_i,
	input  logic  ext_dbg_resume_i
);

	// sticky flag set by any failing property below
	logic assert_hit = 1'b0;

	////////////////////////////////////////
	// protocol properties
	////////////////////////////////////////

	// internal halt on the port only inside a recovery
	halt_needs_busy: assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		(dbg_halt_i && !ext_dbg_halt_i) |-> busy_i
	) else begin
		$error("internal halt while not busy");
		assert_hit = 1'b1;
	end

	// restore write reaches the port as a write and only inside a recovery
	restore_needs_busy: assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		rst_req_i |-> (busy_i && dbg_req_i && dbg_we_i)
	) else begin
		$error("restore write outside of a recovery");
		assert_hit = 1'b1;
	end

	// internal resume is a single cycle pulse
	resume_is_pulse: assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		(dbg_resume_i && !ext_dbg_resume_i) |=> (!dbg_resume_i || ext_dbg_resume_i)
	) else begin
		$error("resume held for two cycles");
		assert_hit = 1'b1;
	end

endmodule

bind ft_unit ft_unit_checker i_checker (
	.clk_i            (clk_i),
	.arst_n_i         (arst_n_i),
	.rst_req_i        (rst_req),
	.busy_i           (busy_o),
	.dbg_req_i        (dbg_req_o),
	.dbg_we_i         (dbg_we_o),
	.dbg_halt_i       (dbg_halt_o),
	.ext_dbg_halt_i   (ext_dbg_halt_i),
	.dbg_resume_i     (dbg_resume_o),
	.ext_dbg_resume_i (ext_dbg_resume_i)
);

`default_nettype wire

//--- logic/ft_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ft_unit (
	input  wire                clk_i,
	input  wire                arst_n_i,
	// register write ports of both cores
	input  logic               we_a_i,
	input  ft_pkg::reg_addr_t  waddr_a_i,
	input  ft_pkg::word_t      wdata_a_i,
	input  ft_pkg::word_t      pc_a_i,
	input  logic               we_b_i,
	input  ft_pkg::reg_addr_t  waddr_b_i,
	input  ft_pkg::word_t      wdata_b_i,
	input  ft_pkg::word_t      pc_b_i,
	// debug halted status
	input  logic               halted_a_i,
	input  logic               halted_b_i,
	// soc debug master
	input  logic               ext_dbg_req_i,
	input  logic               ext_dbg_we_i,
	input  ft_pkg::dbg_addr_t  ext_dbg_addr_i,
	input  ft_pkg::word_t      ext_dbg_wdata_i,
	input  logic               ext_dbg_halt_i,
	input  logic               ext_dbg_resume_i,
	// debug port, drives both cores
	output logic               dbg_req_o,
	output logic               dbg_we_o,
	output ft_pkg::dbg_addr_t  dbg_addr_o,
	output ft_pkg::word_t      dbg_wdata_o,
	output logic               dbg_halt_o,
	output logic               dbg_resume_o,
	// status
	output logic               error_o,
	output logic               busy_o
);

	import ft_pkg::*;

	////////////////////////////////////////
	// internal nets
	////////////////////////////////////////

	// comparator to shadow
	logic      agree_we;
	reg_addr_t agree_addr;
	word_t     agree_data;
	word_t     agree_pc;
	// shadow read port
	reg_addr_t rd_addr;
	word_t     rd_data;
	word_t     saved_pc;
	// sequencer to arbiter
	logic      rst_req;
	dbg_addr_t rst_addr;
	word_t     rst_data;
	logic      int_halt;
	logic      int_resume;

	////////////////////////////////////////
	// instances
	////////////////////////////////////////

	write_compare i_write_compare (
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.we_a_i       (we_a_i),
		.waddr_a_i    (waddr_a_i),
		.wdata_a_i    (wdata_a_i),
		.pc_a_i       (pc_a_i),
		.we_b_i       (we_b_i),
		.waddr_b_i    (waddr_b_i),
		.wdata_b_i    (wdata_b_i),
		.pc_b_i       (pc_b_i),
		.agree_we_o   (agree_we),
		.agree_addr_o (agree_addr),
		.agree_data_o (agree_data),
		.agree_pc_o   (agree_pc),
		.mismatch_o   (error_o)
	);

	shadow_regfile i_shadow_regfile (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.wr_en_i    (agree_we),
		.wr_addr_i  (agree_addr),
		.wr_data_i  (agree_data),
		.wr_pc_i    (agree_pc),
		.rd_addr_i  (rd_addr),
		.rd_data_o  (rd_data),
		.saved_pc_o (saved_pc)
	);

	// error pulse doubles as the recovery trigger
	recovery_fsm i_recovery_fsm (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.mismatch_i (error_o),
		.halted_a_i (halted_a_i),
		.halted_b_i (halted_b_i),
		.rd_addr_o  (rd_addr),
		.rd_data_i  (rd_data),
		.saved_pc_i (saved_pc),
		.rst_req_o  (rst_req),
		.rst_addr_o (rst_addr),
		.rst_data_o (rst_data),
		.halt_o     (int_halt),
		.resume_o   (int_resume),
		.busy_o     (busy_o)
	);

	debug_port_arbiter i_debug_port_arbiter (
		.rst_req_i        (rst_req),
		.rst_addr_i       (rst_addr),
		.rst_data_i       (rst_data),
		.halt_i           (int_halt),
		.resume_i         (int_resume),
		.ext_dbg_req_i    (ext_dbg_req_i),
		.ext_dbg_we_i     (ext_dbg_we_i),
		.ext_dbg_addr_i   (ext_dbg_addr_i),
		.ext_dbg_wdata_i  (ext_dbg_wdata_i),
		.ext_dbg_halt_i   (ext_dbg_halt_i),
		.ext_dbg_resume_i (ext_dbg_resume_i),
		.dbg_req_o        (dbg_req_o),
		.dbg_we_o         (dbg_we_o),
		.dbg_addr_o       (dbg_addr_o),
		.dbg_wdata_o      (dbg_wdata_o),
		.dbg_halt_o       (dbg_halt_o),
		.dbg_resume_o     (dbg_resume_o)
	);

endmodule

`default_nettype wire

//--- recovery/debug_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module debug_port_arbiter (
	// internal restore traffic
	input  logic               rst_req_i,
	input  ft_pkg::dbg_addr_t  rst_addr_i,
	input  ft_pkg::word_t      rst_data_i,
	input  logic               halt_i,
	input  logic               resume_i,
	// soc debug traffic
	input  logic               ext_dbg_req_i,
	input  logic               ext_dbg_we_i,
	input  ft_pkg::dbg_addr_t  ext_dbg_addr_i,
	input  ft_pkg::word_t      ext_dbg_wdata_i,
	input  logic               ext_dbg_halt_i,
	input  logic               ext_dbg_resume_i,
	// shared debug port of both cores
	output logic               dbg_req_o,
	output logic               dbg_we_o,
	output ft_pkg::dbg_addr_t  dbg_addr_o,
	output ft_pkg::word_t      dbg_wdata_o,
	output logic               dbg_halt_o,
	output logic               dbg_resume_o
);

	////////////////////////////////////////
	// access mux
	////////////////////////////////////////

	// restore wins, soc access is not queued
	always_comb begin
		if (rst_req_i) begin
			// restore only ever writes
			dbg_req_o   = 1'b1;
			dbg_we_o    = 1'b1;
			dbg_addr_o  = rst_addr_i;
			dbg_wdata_o = rst_data_i;
		end else begin
			dbg_req_o   = ext_dbg_req_i;
			dbg_we_o    = ext_dbg_we_i;
			dbg_addr_o  = ext_dbg_addr_i;
			dbg_wdata_o = ext_dbg_wdata_i;
		end
	end

	// run control from either side
	assign dbg_halt_o   = halt_i | ext_dbg_halt_i;
	assign dbg_resume_o = resume_i | ext_dbg_resume_i;

endmodule

`default_nettype wire

//--- recovery/recovery_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module recovery_fsm (
	input  wire                clk_i,
	input  wire                arst_n_i,
	// error pulse from the comparator
	input  logic               mismatch_i,
	// debug halted status of both cores
	input  logic               halted_a_i,
	input  logic               halted_b_i,
	// shadow read port
	output ft_pkg::reg_addr_t  rd_addr_o,
	input  ft_pkg::word_t      rd_data_i,
	input  ft_pkg::word_t      saved_pc_i,
	// restore write toward the arbiter
	output logic               rst_req_o,
	output ft_pkg::dbg_addr_t  rst_addr_o,
	output ft_pkg::word_t      rst_data_o,
	// core run control
	output logic               halt_o,
	output logic               resume_o,
	output logic               busy_o
);

	import ft_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_HALT,
		ST_RESTORE,
		ST_RESUME
	} state_t;

	state_t    state_q;
	state_t    state_d;
	// register index being restored
	reg_addr_t idx_q;
	// last restore step, npc instead of a gpr
	logic      shift_q;
	logic      both_halted;
	logic      last_reg;

	assign both_halted = halted_a_i & halted_b_i;
	assign last_reg    = (idx_q == reg_addr_t'(NUM_REGS - 1));

	////////////////////////////////////////
	// next state
	////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		case (state_q)
			// errors while busy are dropped here
			ST_IDLE: begin
				if (mismatch_i) begin
					state_d = ST_HALT;
				end
			end
			// wait length set by the cores
			ST_HALT: begin
				if (both_halted) begin
					state_d = ST_RESTORE;
				end
			end
			// 31 gprs then npc
			ST_RESTORE: begin
				if (shift_q) begin
					state_d = ST_RESUME;
				end
			end
			ST_RESUME: begin
				state_d = ST_IDLE;
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	////////////////////////////////////////
	// state and restore counter
	////////////////////////////////////////

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= ST_IDLE;
			idx_q   <= '0;
			shift_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == ST_HALT) begin
				// x0 is never restored, start at x1
				idx_q   <= reg_addr_t'(1);
				shift_q <= 1'b0;
			end else if (state_q == ST_RESTORE && !shift_q) begin
				if (last_reg) begin
					shift_q <= 1'b1;
				end else begin
					idx_q <= idx_q + reg_addr_t'(1);
				end
			end
		end
	end

	////////////////////////////////////////
	// outputs
	////////////////////////////////////////

	assign rd_addr_o = idx_q;

	// one debug write per restore cycle
	assign rst_req_o = (state_q == ST_RESTORE);

	// debug unit takes aligned accesses only,
	// so the npc step jumps to its own address
	assign rst_addr_o = shift_q ? DBG_NPC_ADDR :
		DBG_REG_BASE + dbg_addr_t'({idx_q, 2'b00});
	assign rst_data_o = shift_q ? saved_pc_i : rd_data_i;

	assign halt_o   = (state_q == ST_HALT);
	assign resume_o = (state_q == ST_RESUME);
	// halt cycle through resume cycle
	assign busy_o   = (state_q != ST_IDLE);

endmodule

`default_nettype wire

//--- logic/shadow_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module shadow_regfile (
	input  wire                clk_i,
	input  wire                arst_n_i,
	// agreed write from the comparator
	input  logic               wr_en_i,
	input  ft_pkg::reg_addr_t  wr_addr_i,
	input  ft_pkg::word_t      wr_data_i,
	input  ft_pkg::word_t      wr_pc_i,
	// combinational read port for the restore
	input  ft_pkg::reg_addr_t  rd_addr_i,
	output ft_pkg::word_t      rd_data_o,
	// resume address
	output ft_pkg::word_t      saved_pc_o
);

	import ft_pkg::*;

	// x1 .. x31 only, x0 is hardwired
	word_t regs_q [1:NUM_REGS-1];
	// pc of the last agreed write
	word_t pc_q;

	////////////////////////////////////////
	// checkpoint storage
	////////////////////////////////////////

	// cleared on reset so a restore before any
	// agreed write puts zeros back into the cores
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wr_en_i && (wr_addr_i != '0)) begin
			regs_q[wr_addr_i] <= wr_data_i;
		end
	end

	// x0 writes still retire an instruction
	// so the pc moves on every agreed write
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q <= '0;
		end else if (wr_en_i) begin
			pc_q <= wr_pc_i;
		end
	end

	////////////////////////////////////////
	// read side
	////////////////////////////////////////

	always_comb begin
		if (rd_addr_i == '0) begin
			rd_data_o = '0;
		end else begin
			rd_data_o = regs_q[rd_addr_i];
		end
	end

	// restart after the checkpointed instruction
	assign saved_pc_o = pc_q + INSTR_BYTES;

endmodule

`default_nettype wire

//--- logic/write_compare.sv
`timescale 1ns/1ps
`default_nettype none

module write_compare (
	input  wire                clk_i,
	input  wire                arst_n_i,
	// core a write port
	input  logic               we_a_i,
	input  ft_pkg::reg_addr_t  waddr_a_i,
	input  ft_pkg::word_t      wdata_a_i,
	input  ft_pkg::word_t      pc_a_i,
	// core b write port
	input  logic               we_b_i,
	input  ft_pkg::reg_addr_t  waddr_b_i,
	input  ft_pkg::word_t      wdata_b_i,
	input  ft_pkg::word_t      pc_b_i,
	// agreed write toward the shadow
	output logic               agree_we_o,
	output ft_pkg::reg_addr_t  agree_addr_o,
	output ft_pkg::word_t      agree_data_o,
	output ft_pkg::word_t      agree_pc_o,
	// one cycle error pulse
	output logic               mismatch_o
);

	logic wr_cycle;
	logic fields_differ;

	// either core writing counts as a write cycle
	assign wr_cycle = we_a_i | we_b_i;

	// field by field compare
	// a lone enable is a mismatch on its own
	assign fields_differ = (we_a_i != we_b_i) ||
		(waddr_a_i != waddr_b_i) ||
		(wdata_a_i != wdata_b_i) ||
		(pc_a_i != pc_b_i);

	// strobes, one cycle after the sampling edge
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mismatch_o <= 1'b0;
			agree_we_o <= 1'b0;
		end else begin
			mismatch_o <= wr_cycle & fields_differ;
			agree_we_o <= wr_cycle & ~fields_differ;
		end
	end

	// payload follows the strobe
	// core a copy is enough, only used when both agree
	always_ff @(posedge clk_i) begin
		if (wr_cycle) begin
			agree_addr_o <= waddr_a_i;
			agree_data_o <= wdata_a_i;
			agree_pc_o   <= pc_a_i;
		end
	end

endmodule

`default_nettype wire

//--- common/ft_pkg.sv
`default_nettype none

package ft_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	// data word and program counter
	localparam int XLEN = 32;
	// architectural registers, x0 included
	localparam int NUM_REGS = 32;
	localparam int REG_ADDR_W = 5;
	// core debug unit address bus
	localparam int DBG_ADDR_W = 15;

	////////////////////////////////////////
	// types
	////////////////////////////////////////

	// one data word or one pc
	typedef logic [XLEN-1:0] word_t;
	// register index
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	// debug unit address
	typedef logic [DBG_ADDR_W-1:0] dbg_addr_t;

	////////////////////////////////////////
	// debug unit map
	////////////////////////////////////////

	// gpr x0, word aligned, xi at base + 4*i
	localparam dbg_addr_t DBG_REG_BASE = 15'h0400;
	// next pc register of the debug unit
	localparam dbg_addr_t DBG_NPC_ADDR = 15'h2000;

	// restore point is the instruction after the last agreed write
	localparam word_t INSTR_BYTES = 32'd4;

endpackage

`default_nettype wire
